// ==== flist.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_resp_if.sv
hdl/dummy_inserter.sv
hdl/prefetch_unit.sv
hdl/if_stage.sv
hdl/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_subsystem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_resp_if.sv
      - hdl/dummy_inserter.sv
      - hdl/prefetch_unit.sv
      - hdl/if_stage.sv
      - hdl/fetch_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_fetch_top.sv

// ==== testbench/tb_fetch_top.sv ====
// Testbench for the fetch subsystem
// Instruction bus memory model, typed compare tasks and directed tests
`include "fetch_settings.svh"

module tb_fetch_top;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  // Addresses in [ERR_LO, ERR_HI) answer with a bus error
  localparam addr_t       ERR_LO    = 32'h0000_0400;
  localparam addr_t       ERR_HI    = 32'h0000_0410;
  localparam logic [31:0] INSTR_KEY = 32'h5a5a_0013;

  logic     clk;
  logic     rst_n;
  logic     instr_req_o;
  addr_t    instr_addr_o;
  logic     instr_gnt_i;
  logic     instr_rvalid_i;
  instr_t   instr_rdata_i;
  logic     instr_err_i;
  logic     pc_set_i;
  addr_t    branch_addr_i;
  privlvl_t priv_lvl_i;
  logic     halt_i;
  logic     kill_i;
  logic     dummy_en_i;
  logic     if_valid_o;
  addr_t    pc_o;
  instr_t   instr_o;
  privlvl_t priv_o;
  logic     bus_err_o;
  logic     is_dummy_o;
  logic     id_ready_i;

  // Memory model state, granted requests wait here for their response
  logic [31:0] rng_q;
  addr_t       pend_addr [$];
  int          pend_due [$];
  int          gnt_wait;
  int          cyc;

  // Expected stream and bookkeeping
  addr_t    exp_pc;
  privlvl_t exp_priv;
  int       real_cnt;
  int       dummy_cnt;
  int       since_dummy;
  bit       last_dummy;
  bit       seen_dummy;
  int       checks;
  int       errors;
  int       tests;
  int       checks_at_start;
  int       errors_at_start;
  bit       timed_out;

  fetch_top i_fetch_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr_i),
    .priv_lvl_i     (priv_lvl_i),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .dummy_en_i     (dummy_en_i),
    .if_valid_o     (if_valid_o),
    .pc_o           (pc_o),
    .instr_o        (instr_o),
    .priv_o         (priv_o),
    .bus_err_o      (bus_err_o),
    .is_dummy_o     (is_dummy_o),
    .id_ready_i     (id_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    rng_q = xorshift32(rng_q);
    return rng_q % n;
  endfunction

  function automatic logic in_err_range(input addr_t a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_instr(input string what, input instr_t got, input instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_priv(input string what, input privlvl_t got, input privlvl_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input string what, input bit cond);
    checks++;
    if (!cond) begin
      errors++;
      $display("[ERROR] %0t: %s", $time, what);
    end
  endtask

  ////////////////////
  // Bus model and monitor
  ////////////////////

  // Drives grant and response for the coming rising edge, in order and
  // at least one cycle after the grant
  task automatic bus_step();
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    if (!rst_n) begin
      pend_addr.delete();
      pend_due.delete();
      gnt_wait = -1;
    end else begin
      if (instr_req_o) begin
        if (gnt_wait < 0) begin
          gnt_wait = int'(rand_below(4));
        end
        if (gnt_wait == 0) begin
          instr_gnt_i = 1'b1;
          pend_addr.push_back(instr_addr_o);
          pend_due.push_back(cyc + 1 + int'(rand_below(4)));
          gnt_wait = -1;
        end else begin
          gnt_wait--;
        end
      end
      if ((pend_addr.size() > 0) && (pend_due[0] <= cyc)) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = pend_addr[0] ^ INSTR_KEY;
        instr_err_i    = in_err_range(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
    cyc++;
  endtask

  // Checks one instruction handed to decode against the expected stream
  task automatic check_xfer();
    check_priv("priv_o", priv_o, exp_priv);
    check_addr("pc_o", pc_o, exp_pc);
    if (is_dummy_o) begin
      dummy_cnt++;
      check_true("dummy instruction while dummies are disabled", dummy_en_i);
      check_true("two dummy instructions in a row", !last_dummy);
      if (seen_dummy) begin
        check_true("too few real instructions between dummies",
                   since_dummy >= `DUMMY_MIN_GAP);
      end
      // ADDI with rd x0, so opcode, rd and funct3 are fixed
      check_instr("dummy encoding", instr_o & 32'h0000_7fff, 32'h0000_0013);
      check_flag("bus_err_o of a dummy", bus_err_o, 1'b0);
      last_dummy  = 1'b1;
      seen_dummy  = 1'b1;
      since_dummy = 0;
    end else begin
      check_instr("instr_o", instr_o, exp_pc ^ INSTR_KEY);
      check_flag("bus_err_o", bus_err_o, in_err_range(exp_pc));
      real_cnt++;
      since_dummy++;
      last_dummy = 1'b0;
      exp_pc     = exp_pc + 32'd4;
    end
  endtask

  // Called at a falling edge once the inputs for the next rising edge are set
  task automatic tick();
    if (rst_n && if_valid_o && id_ready_i && !kill_i) begin
      check_xfer();
    end
    bus_step();
    @(negedge clk);
  endtask

  task automatic run_reals(input int n, input bit random_ready);
    int target;
    int waited;
    target = real_cnt + n;
    waited = 0;
    while ((real_cnt < target) && !timed_out) begin
      if (waited == 50 * n + 50) begin
        $display("Timeout, only %0d of %0d instructions reached decode",
                 n - (target - real_cnt), n);
        timed_out = 1'b1;
      end else begin
        id_ready_i = random_ready ? 1'(rand_below(2)) : 1'b1;
        tick();
        waited++;
      end
    end
  endtask

  task automatic wait_req(input int limit);
    int waited;
    waited = 0;
    while (!instr_req_o && !timed_out) begin
      if (waited == limit) begin
        $display("Timeout, no instruction request after reset");
        timed_out = 1'b1;
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  task automatic wait_pending(input int limit);
    int waited;
    waited = 0;
    while ((pend_addr.size() == 0) && !timed_out) begin
      if (waited == limit) begin
        $display("Timeout, no request stayed outstanding on the bus");
        timed_out = 1'b1;
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  // Leaves id_ready_i as it is, so a held instruction stays in the pipe
  task automatic wait_valid(input int limit);
    int waited;
    waited = 0;
    while (!if_valid_o && !timed_out) begin
      if (waited == limit) begin
        $display("Timeout, no instruction became valid towards decode");
        timed_out = 1'b1;
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  // Redirect as the controller does it, with kill in the same cycle
  task automatic redirect(input addr_t target, input privlvl_t priv);
    id_ready_i    = 1'b0;
    pc_set_i      = 1'b1;
    kill_i        = 1'b1;
    branch_addr_i = target;
    priv_lvl_i    = priv;
    tick();
    pc_set_i   = 1'b0;
    kill_i     = 1'b0;
    exp_pc     = target;
    exp_priv   = priv;
    last_dummy = 1'b0;
  endtask

  task automatic start_test();
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-10s done, %0d checks, %0d errors", name,
             checks - checks_at_start, errors - errors_at_start);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset();
    start_test();
    rst_n      = 1'b0;
    id_ready_i = 1'b0;
    exp_pc     = `FETCH_BOOT_ADDR;
    exp_priv   = PRIV_LVL_M;
    repeat (4) begin
      check_flag("instr_req_o in reset", instr_req_o, 1'b0);
      check_flag("if_valid_o in reset", if_valid_o, 1'b0);
      tick();
    end
    rst_n = 1'b1;
    check_flag("instr_req_o after reset", instr_req_o, 1'b0);
    check_flag("if_valid_o after reset", if_valid_o, 1'b0);
    tick();
    wait_req(8);
    if (!timed_out) begin
      check_addr("first request address", instr_addr_o, `FETCH_BOOT_ADDR);
    end
    end_test("reset");
  endtask

  task automatic test_stream();
    start_test();
    run_reals(24, 1'b1);
    end_test("stream");
  endtask

  // Old-path responses are still on the bus when the redirect comes
  task automatic test_redirect();
    start_test();
    run_reals(4, 1'b0);
    wait_pending(40);
    if (!timed_out) begin
      redirect(32'h0000_0200, PRIV_LVL_M);
      run_reals(8, 1'b0);
    end
    end_test("redirect");
  endtask

  // Decode holds back so that a valid instruction sits in the pipe during halt
  task automatic test_halt();
    start_test();
    run_reals(3, 1'b0);
    id_ready_i = 1'b0;
    wait_valid(20);
    if (!timed_out) begin
      halt_i = 1'b1;
      tick();
      repeat (6) begin
        check_flag("if_valid_o while halted", if_valid_o, 1'b0);
        tick();
      end
      halt_i = 1'b0;
      run_reals(6, 1'b0);
    end
    end_test("halt");
  endtask

  // Start a few words below the error range so the stream runs across it
  task automatic test_priv_err();
    start_test();
    redirect(ERR_LO - 32'd8, PRIV_LVL_U);
    run_reals(10, 1'b1);
    end_test("priv_err");
  endtask

  task automatic test_dummy();
    int dummies_before;
    start_test();
    dummies_before = dummy_cnt;
    seen_dummy     = 1'b0;
    dummy_en_i     = 1'b1;
    run_reals(40, 1'b1);
    check_true("no dummy instructions were inserted", dummy_cnt - dummies_before >= 2);
    end_test("dummy");
  endtask

  initial begin
    rng_q          = 32'h9c25;
    rst_n          = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    pc_set_i       = 1'b0;
    branch_addr_i  = '0;
    priv_lvl_i     = PRIV_LVL_M;
    halt_i         = 1'b0;
    kill_i         = 1'b0;
    dummy_en_i     = 1'b0;
    id_ready_i     = 1'b0;
    gnt_wait       = -1;
    cyc            = 0;
    real_cnt       = 0;
    dummy_cnt      = 0;
    since_dummy    = 0;
    last_dummy     = 1'b0;
    seen_dummy     = 1'b0;
    checks         = 0;
    errors         = 0;
    tests          = 0;
    timed_out      = 1'b0;
    @(negedge clk);

    test_reset();
    if (!timed_out) test_stream();
    if (!timed_out) test_redirect();
    if (!timed_out) test_halt();
    if (!timed_out) test_priv_err();
    if (!timed_out) test_dummy();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if ((errors == 0) && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/fetch_top.sv ====
// Fetch subsystem top level
// Prefetch unit and IF stage joined by the response channel
module fetch_top (
  input  logic                clk,
  input  logic                rst_n,
  // Instruction bus
  output logic                instr_req_o,
  output fetch_pkg::addr_t    instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  fetch_pkg::instr_t   instr_rdata_i,
  input  logic                instr_err_i,
  // Controller
  input  logic                pc_set_i,
  input  fetch_pkg::addr_t    branch_addr_i,
  input  fetch_pkg::privlvl_t priv_lvl_i,
  input  logic                halt_i,
  input  logic                kill_i,
  input  logic                dummy_en_i,
  // Decode
  output logic                if_valid_o,
  output fetch_pkg::addr_t    pc_o,
  output fetch_pkg::instr_t   instr_o,
  output fetch_pkg::privlvl_t priv_o,
  output logic                bus_err_o,
  output logic                is_dummy_o,
  input  logic                id_ready_i
);
  import fetch_pkg::*;

  privlvl_t    resp_priv;
  if_id_pipe_t if_id_pipe;

  fetch_resp_if resp_if ();

  prefetch_unit i_prefetch_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr_i),
    .priv_lvl_i     (priv_lvl_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .resp           (resp_if.prefetcher),
    .resp_priv_o    (resp_priv)
  );

  if_stage i_if_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .halt_i       (halt_i),
    .kill_i       (kill_i),
    .dummy_en_i   (dummy_en_i),
    .id_ready_i   (id_ready_i),
    .resp         (resp_if.stage),
    .resp_priv_i  (resp_priv),
    .if_valid_o   (if_valid_o),
    .if_id_pipe_o (if_id_pipe)
  );

  // Pipe fields towards decode
  assign pc_o       = if_id_pipe.pc;
  assign instr_o    = if_id_pipe.instr;
  assign priv_o     = if_id_pipe.priv_lvl;
  assign bus_err_o  = if_id_pipe.bus_err;
  assign is_dummy_o = if_id_pipe.is_dummy;

endmodule

// ==== hdl/if_stage.sv ====
// IF stage with halt and kill control and dummy selection
// Privilege tagging, IF/ID pipe register and stage checks
module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   halt_i,
  input  logic                   kill_i,
  input  logic                   dummy_en_i,
  input  logic                   id_ready_i,
  fetch_resp_if.stage            resp,
  input  fetch_pkg::privlvl_t    resp_priv_i,
  output logic                   if_valid_o,
  output fetch_pkg::if_id_pipe_t if_id_pipe_o
);
  import fetch_pkg::*;

  logic        if_ready;
  logic        valid_q;
  logic        halt_q;
  logic        load;
  logic        dummy_insert;
  logic        dummy_sel;
  instr_t      dummy_instr;
  if_id_pipe_t pipe_d;
  if_id_pipe_t pipe_q;
  logic        priv_changed_q;
  privlvl_t    priv_new_q;

  // Advances on every load into the pipe register
  dummy_inserter i_dummy_inserter (
    .clk           (clk),
    .rst_n         (rst_n),
    .dummy_en_i    (dummy_en_i),
    .advance_i     (load),
    .insert_o      (dummy_insert),
    .dummy_instr_o (dummy_instr)
  );

  ////////////////////
  // Handshake
  ////////////////////

  // A halted stage hides its contents from ID one cycle later
  assign if_valid_o = valid_q & ~halt_q;

  // Kill always accepts, halt never does
  assign if_ready = kill_i | (~halt_i & (~valid_q | (if_valid_o & id_ready_i)));

  // A dummy needs a real head entry to borrow its PC
  assign dummy_sel = dummy_insert & resp.resp_valid;
  assign load      = if_ready & ~kill_i & resp.resp_valid;

  // Under kill the head is dropped even when a dummy was due
  assign resp.resp_pop = if_ready & resp.resp_valid & (kill_i | ~dummy_sel);

  always_comb begin
    pipe_d.instr_valid = 1'b1;
    pipe_d.instr       = dummy_sel ? dummy_instr : resp.resp_instr;
    pipe_d.pc          = resp.resp_addr;
    pipe_d.priv_lvl    = resp_priv_i;
    pipe_d.bus_err     = resp.resp_err & ~dummy_sel;
    pipe_d.is_dummy    = dummy_sel;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      halt_q  <= 1'b0;
    end else begin
      halt_q <= halt_i & ~kill_i;
      if (kill_i) begin
        valid_q <= 1'b0;
      end else if (load) begin
        valid_q <= 1'b1;
      end else if (if_valid_o && id_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pipe_q <= pipe_d;
    end
  end

  always_comb begin
    if_id_pipe_o             = pipe_q;
    if_id_pipe_o.instr_valid = if_valid_o;
  end

  ////////////////////
  // Checks
  ////////////////////

  a_halt :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (halt_i && !kill_i) |-> !if_ready ##1 !if_valid_o)
      else $error("Halt must block the stage and drop valid");

  a_kill :
    assert property (@(posedge clk) disable iff (!rst_n)
                     kill_i |-> if_ready ##1 !if_valid_o)
      else $error("Kill must accept and drop valid");

  // The head entry stays in the buffer behind a dummy
  a_no_pop_on_dummy :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (dummy_sel && !kill_i) |=>
                     (resp.resp_valid && (resp.resp_addr == $past(resp.resp_addr))))
      else $error("Response buffer popped during a dummy instruction");

  // Remembers a privilege change until an instruction reaches ID
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_changed_q <= 1'b0;
      priv_new_q     <= PRIV_LVL_M;
    end else if (resp_priv_i != priv_new_q) begin
      priv_changed_q <= 1'b1;
      priv_new_q     <= resp_priv_i;
    end else if (if_valid_o) begin
      priv_changed_q <= 1'b0;
    end
  end

  a_priv_change :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (priv_changed_q && if_valid_o) |-> (if_id_pipe_o.priv_lvl == priv_new_q))
      else $error("Stale privilege level sent to ID");

endmodule

// ==== hdl/prefetch_unit.sv ====
// Prefetch unit with its request FSM and outstanding/discard counters
// In-order response buffer feeding the IF stage
`include "fetch_settings.svh"

module prefetch_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pc_set_i,
  input  fetch_pkg::addr_t    branch_addr_i,
  input  fetch_pkg::privlvl_t priv_lvl_i,
  output logic                instr_req_o,
  output fetch_pkg::addr_t    instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  fetch_pkg::instr_t   instr_rdata_i,
  input  logic                instr_err_i,
  fetch_resp_if.prefetcher    resp,
  output fetch_pkg::privlvl_t resp_priv_o
);
  import fetch_pkg::*;

  localparam int unsigned CNT_W = $clog2(`FETCH_BUF_DEPTH + `FETCH_MAX_OUTSTANDING + 1);
  localparam int unsigned PTR_W = (`FETCH_BUF_DEPTH > 1) ? $clog2(`FETCH_BUF_DEPTH) : 1;
  localparam logic [CNT_W-1:0] BUF_DEPTH = CNT_W'(`FETCH_BUF_DEPTH);
  localparam logic [CNT_W-1:0] MAX_OUTST = CNT_W'(`FETCH_MAX_OUTSTANDING);
  localparam logic [PTR_W-1:0] PTR_LAST  = PTR_W'(`FETCH_BUF_DEPTH - 1);

  fetch_state_t     state_q;
  fetch_state_t     state_d;
  logic             req_q;
  logic             req_d;
  addr_t            addr_q;
  addr_t            addr_d;
  addr_t            branch_q;
  addr_t            branch_aligned;
  addr_t            resp_addr_q;
  privlvl_t         priv_q;
  logic [CNT_W-1:0] outst_q;
  logic [CNT_W-1:0] outst_d;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W-1:0] discard_d;
  logic [CNT_W-1:0] buf_cnt_q;
  logic [CNT_W-1:0] buf_cnt_d;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  instr_t           buf_instr_q [`FETCH_BUF_DEPTH];
  addr_t            buf_addr_q  [`FETCH_BUF_DEPTH];
  logic             buf_err_q   [`FETCH_BUF_DEPTH];
  logic             gnt_fire;
  logic             pending;
  logic             push;
  logic             pop;
  logic             space;

  // Fetches are always word-aligned
  assign branch_aligned = {branch_addr_i[31:2], 2'b00};

  assign gnt_fire = req_q & instr_gnt_i;
  // A raised request must be held until its grant
  assign pending  = req_q & ~instr_gnt_i;
  assign pop      = resp.resp_valid & resp.resp_pop;
  // Old-path responses are dropped, and so is anything arriving with a redirect
  assign push     = instr_rvalid_i & (discard_q == '0) & ~pc_set_i;

  assign outst_d   = outst_q + CNT_W'(gnt_fire) - CNT_W'(instr_rvalid_i);
  assign buf_cnt_d = pc_set_i ? '0 : buf_cnt_q + CNT_W'(push) - CNT_W'(pop);

  // Next-cycle room for one more response so that rvalid is never refused
  assign space = ((buf_cnt_d + outst_d) < BUF_DEPTH) && (outst_d < MAX_OUTST);

  ////////////////////
  // Discard tracking
  ////////////////////

  always_comb begin
    discard_d = discard_q;
    if (pc_set_i) begin
      // Everything still in flight belongs to the old path
      discard_d = outst_d;
    end else begin
      // The held old-path request joins the discard count once granted
      if ((state_q == FETCH_FLUSH) && gnt_fire) begin
        discard_d = discard_d + CNT_W'(1);
      end
      if (instr_rvalid_i && (discard_q != '0)) begin
        discard_d = discard_d - CNT_W'(1);
      end
    end
  end

  ////////////////////
  // Request FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    req_d   = req_q;
    addr_d  = addr_q;
    if (pc_set_i) begin
      if (pending) begin
        // Keep the old request up and park the target until the grant
        state_d = FETCH_FLUSH;
        req_d   = 1'b1;
      end else begin
        state_d = FETCH_REQ;
        addr_d  = branch_aligned;
        req_d   = space;
      end
    end else begin
      unique case (state_q)
        FETCH_IDLE: begin
          state_d = FETCH_REQ;
          req_d   = space;
        end
        FETCH_REQ: begin
          if (gnt_fire) begin
            addr_d = addr_q + 32'd4;
          end
          req_d = pending | space;
        end
        FETCH_FLUSH: begin
          // Switch to the new path as soon as the old request is granted
          if (gnt_fire) begin
            state_d = FETCH_REQ;
            addr_d  = branch_q;
            req_d   = space;
          end
        end
        default: begin
          state_d = FETCH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= FETCH_IDLE;
      req_q       <= 1'b0;
      addr_q      <= `FETCH_BOOT_ADDR;
      resp_addr_q <= `FETCH_BOOT_ADDR;
      priv_q      <= PRIV_LVL_M;
      outst_q     <= '0;
      discard_q   <= '0;
      buf_cnt_q   <= '0;
      rd_ptr_q    <= '0;
      wr_ptr_q    <= '0;
    end else begin
      state_q   <= state_d;
      req_q     <= req_d;
      addr_q    <= addr_d;
      outst_q   <= outst_d;
      discard_q <= discard_d;
      buf_cnt_q <= buf_cnt_d;
      if (pc_set_i) begin
        // Buffer is emptied and the new path starts at the target
        resp_addr_q <= branch_aligned;
        priv_q      <= priv_lvl_i;
        rd_ptr_q    <= '0;
        wr_ptr_q    <= '0;
      end else begin
        if (push) begin
          resp_addr_q <= resp_addr_q + 32'd4;
          wr_ptr_q    <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + PTR_W'(1);
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + PTR_W'(1);
        end
      end
    end
  end

  // Response storage and redirect target
  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      branch_q <= branch_aligned;
    end
    if (push) begin
      buf_instr_q[wr_ptr_q] <= instr_rdata_i;
      buf_addr_q[wr_ptr_q]  <= resp_addr_q;
      buf_err_q[wr_ptr_q]   <= instr_err_i;
    end
  end

  assign instr_req_o     = req_q;
  assign instr_addr_o    = addr_q;
  assign resp.resp_valid = (buf_cnt_q != '0);
  assign resp.resp_instr = buf_instr_q[rd_ptr_q];
  assign resp.resp_addr  = buf_addr_q[rd_ptr_q];
  assign resp.resp_err   = buf_err_q[rd_ptr_q];
  assign resp_priv_o     = priv_q;

  a_req_aligned :
    assert property (@(posedge clk) disable iff (!rst_n)
                     instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
      else $error("Instruction request to a misaligned address");

  a_outst_limit :
    assert property (@(posedge clk) disable iff (!rst_n)
                     outst_q <= MAX_OUTST)
      else $error("Too many instruction requests in flight");

endmodule

// ==== hdl/dummy_inserter.sv ====
// Dummy instruction inserter for side-channel hardening
// LFSR gap draw, real-instruction counter and ADDI encoding
`include "fetch_settings.svh"

module dummy_inserter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dummy_en_i,
  input  logic              advance_i,
  output logic              insert_o,
  output fetch_pkg::instr_t dummy_instr_o
);
  import fetch_pkg::*;

  localparam int unsigned GAP_W = $clog2(2 * `DUMMY_MIN_GAP + 1);
  localparam logic [GAP_W-1:0] MIN_GAP = GAP_W'(`DUMMY_MIN_GAP);

  logic [15:0]      lfsr_q;
  logic             lfsr_fb;
  logic [GAP_W-1:0] gap_q;
  logic [GAP_W-1:0] gap_draw;
  logic [GAP_W-1:0] cnt_q;

  // Taps 16, 14, 13 and 11 give a maximal length sequence
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // Next gap lies between MIN_GAP and twice MIN_GAP
  assign gap_draw = MIN_GAP + GAP_W'(lfsr_q % (`DUMMY_MIN_GAP + 1));

  // Raised once enough real instructions went to ID
  assign insert_o = dummy_en_i & (cnt_q >= gap_q);

  // ADDI x0 with a random source register and immediate
  assign dummy_instr_o = {lfsr_q[11:0], lfsr_q[15:11], 3'b000, 5'd0, DUMMY_OPCODE};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= 16'hace1;
      gap_q  <= MIN_GAP;
      cnt_q  <= '0;
    end else begin
      // The LFSR runs freely so the draw depends on timing too
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      if (advance_i) begin
        if (insert_o) begin
          // The dummy itself left, start a new gap
          cnt_q <= '0;
          gap_q <= gap_draw;
        end else if (cnt_q < gap_q) begin
          cnt_q <= cnt_q + GAP_W'(1);
        end
      end
    end
  end

  a_no_back_to_back :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (advance_i && insert_o) ##1 advance_i[->1] |-> !insert_o)
      else $error("Two dummy instructions in a row");

endmodule

// ==== hdl/fetch_resp_if.sv ====
// Response channel between the prefetch buffer and the IF stage
interface fetch_resp_if;
  import fetch_pkg::*;

  // Head entry of the response buffer
  logic   resp_valid;
  instr_t resp_instr;
  addr_t  resp_addr;
  logic   resp_err;

  // Consumes the head entry and is only high while resp_valid is high
  logic   resp_pop;

  // The prefetcher owns the buffer head
  modport prefetcher (
    output resp_valid,
    output resp_instr,
    output resp_addr,
    output resp_err,
    input  resp_pop
  );

  // The IF stage decides when the head is consumed
  modport stage (
    input  resp_valid,
    input  resp_instr,
    input  resp_addr,
    input  resp_err,
    output resp_pop
  );

endinterface

// ==== hdl/fetch_pkg.sv ====
// Shared types of the fetch subsystem
// Address and instruction words, privilege levels, prefetcher FSM, IF/ID pipe
package fetch_pkg;

  // Byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // Uncompressed 32-bit instruction word
  typedef logic [31:0] instr_t;

  // Only user and machine mode exist in this core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  // Prefetcher states
  // FLUSH waits for the grant of a request raised before a redirect
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_FLUSH
  } fetch_state_t;

  // Every dummy is an ADDI and so carries the OP-IMM opcode
  localparam logic [6:0] DUMMY_OPCODE = 7'b0010011;

  ////////////////////
  // IF/ID pipe
  ////////////////////

  typedef struct packed {
    logic     instr_valid;
    instr_t   instr;
    addr_t    pc;
    privlvl_t priv_lvl;
    logic     bus_err;
    logic     is_dummy;
  } if_id_pipe_t;

endpackage

// ==== hdl/fetch_settings.svh ====
// Build-time settings of the fetch subsystem
// Response buffer depth, outstanding limit, dummy spacing, boot PC
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Entries in the prefetch response buffer
`define FETCH_BUF_DEPTH 2

// Requests allowed in flight on the instruction bus
`define FETCH_MAX_OUTSTANDING 2

// Smallest number of real instructions between two dummies
`define DUMMY_MIN_GAP 4

// First fetch address after reset
`define FETCH_BOOT_ADDR 32'h0000_0080

`endif
